// File: Bender.yml
package:
  name: ap

sources:
  - ap_pkg.sv
  - ap_issue.sv
  - ap_slice_unit.sv
  - ap_word_unit.sv
  - ap_reg_array.sv
  - ap_top.sv
  - target: test
    files:
      - ap_checker.sv
      - ap_tb.sv

// File: ap.f
ap_pkg.sv
ap_issue.sv
ap_slice_unit.sv
ap_word_unit.sv
ap_reg_array.sv
ap_top.sv
ap_checker.sv
ap_tb.sv

// File: ap_checker.sv
module ap_checker
    import ap_pkg::*;
#(
    parameter int RESULT_CREDITS = 2
) (
    input  logic     sys_clk_i,
    input  logic     arst_n_i,
    input  logic     result_valid_i,
    input  column_t  result_i,
    input  logic     instr_credit_i,
    input  logic     result_credit_i
);
    timeunit 1ns;
    timeprecision 100ps;

    string   exp_name_q [$];
    column_t exp_val_q [$];
    int      result_count     = 0;
    int      credit_ret_count = 0;
    int      icredit_count    = 0;
    int      value_errors     = 0;
    int      proto_errors     = 0;

    task automatic expect_result(input string name, input column_t value);
        exp_name_q.push_back(name);
        exp_val_q.push_back(value);
    endtask

    task automatic check_result(input column_t actual);
        string   name;
        column_t expected;
        result_count++;
        // Only credits returned in earlier cycles can cover this result
        if (result_count - credit_ret_count > RESULT_CREDITS) begin
            proto_errors++;
            $display("%0t: result_valid_o seen with no result credit outstanding", $time);
        end
        if (exp_val_q.size() == 0) begin
            proto_errors++;
            $display("%0t: result %h arrived with no store pending", $time, actual);
        end else begin
            name     = exp_name_q.pop_front();
            expected = exp_val_q.pop_front();
            if (actual !== expected) begin
                value_errors++;
                $display("** Error %0t: test %s expected %h actual %h",
                         $time, name, expected, actual);
            end
        end
    endtask

    task automatic verify_totals(input int sent);
        if (exp_val_q.size() != 0) begin
            proto_errors++;
            $display("%0d store results never arrived", exp_val_q.size());
        end
        if (icredit_count != sent) begin
            proto_errors++;
            $display("%0d instruction credits returned for %0d instructions sent",
                     icredit_count, sent);
        end
    endtask

    // Outputs settle mid-cycle, so sample on the falling edge
    always @(negedge sys_clk_i) begin
        if (!arst_n_i) begin
            if (instr_credit_i || result_valid_i) begin
                proto_errors++;
                $display("%0t: credit or result pulse while in reset", $time);
            end
        end else begin
            if (result_valid_i) check_result(result_i);
            if (result_credit_i) credit_ret_count++;
            if (instr_credit_i) icredit_count++;
        end
    end

endmodule

// File: ap_issue.sv
module ap_issue
    import ap_pkg::*;
#(
    parameter int ISSUE_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic         sys_clk_i,
    input  logic         arst_n_i,
    input  logic         instr_valid_i,
    input  instr_t       instr_i,
    input  logic         result_credit_i,
    input  logic         rd_valid_i,
    input  column_t      rd_data_i,
    output logic         instr_credit_o,
    output logic         exec_en_o,
    output op_e          exec_op_o,
    output sel_e         exec_sel_o,
    output row_idx_t     exec_idx_o,
    output imm_t         exec_imm_o,
    output logic         result_valid_o,
    output column_t      result_o
);

    localparam int PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);
    localparam int CRD_W = $clog2(RESULT_CREDITS + 1);

    instr_t           fifo_mem [ISSUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CRD_W-1:0] credit_cnt_q;
    issue_state_e     state_d;
    instr_t           head;
    logic             empty;
    logic             full;
    logic             pop;
    logic             head_is_store;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count_q == '0);
    assign full  = (count_q == CNT_W'(ISSUE_DEPTH));

    // Head decode, upper index bits are spare
    assign head          = fifo_mem[rd_ptr_q];
    assign exec_op_o     = op_e'(head[OP_LSB +: 4]);
    assign exec_idx_o    = head[IDX_LSB +: 4];
    assign exec_sel_o    = sel_e'(head[SEL_LSB +: 2]);
    assign exec_imm_o    = head[15:0];
    assign head_is_store = (exec_op_o == STORERBR) || (exec_op_o == STORECBC);

    // A store with no credit holds the head, and everything behind it
    always_comb begin
        state_d = IDLE;
        if (!empty && head_is_store && credit_cnt_q == '0) begin
            state_d = WAIT_CREDIT;
        end
    end

    assign pop            = !empty && (state_d == IDLE);
    assign exec_en_o      = pop;
    assign instr_credit_o = pop;    // Slot frees in the execute cycle

    always_ff @(posedge sys_clk_i) begin
        if (instr_valid_i) begin
            fifo_mem[wr_ptr_q] <= instr_i;
        end
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            credit_cnt_q <= CRD_W'(RESULT_CREDITS);
        end else begin
            if (instr_valid_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({instr_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Credit is taken at issue so back-to-back stores cannot overrun
            case ({pop && head_is_store, result_credit_i})
                2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    assign result_valid_o = rd_valid_i;
    assign result_o       = rd_data_i;  // Already registered in the slice unit

    a_no_push_when_full: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        instr_valid_i |-> !full)
        else $error("instruction sent without a queue credit");

    a_credit_bound: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        credit_cnt_q <= RESULT_CREDITS)
        else $error("result credit counter overflow");

endmodule

// File: ap_pkg.sv
package ap_pkg;

    localparam int AP_ROWS = 16;

    // Instruction field positions, opcode in the top bits
    localparam int OP_LSB  = 26;
    localparam int IDX_LSB = 18;
    localparam int SEL_LSB = 16;

    typedef logic [7:0]  word_t;
    typedef logic [3:0]  row_idx_t;
    typedef logic [15:0] column_t;  // One bit per row, row 0 in bit 0
    typedef logic [15:0] imm_t;
    typedef logic [29:0] instr_t;

    typedef word_t [AP_ROWS-1:0] array_img_t;

    typedef enum logic [3:0] {
        RESET    = 4'd1,
        LOADRBR  = 4'd4,
        LOADCBC  = 4'd5,
        STORERBR = 4'd6,
        STORECBC = 4'd7,
        COPY     = 4'd8,
        ADD      = 4'd9,
        SUB      = 4'd10,
        TSC      = 4'd11,
        ABS      = 4'd12
    } op_e;

    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_A    = 2'd1,
        SEL_B    = 2'd2,
        SEL_R    = 2'd3
    } sel_e;

    typedef enum logic {
        IDLE,
        WAIT_CREDIT
    } issue_state_e;

    // Array image named by a selector, zero for SEL_NONE
    function automatic array_img_t pick_img(input sel_e sel, input array_img_t a,
                                            input array_img_t b, input array_img_t r);
        case (sel)
            SEL_A:   return a;
            SEL_B:   return b;
            SEL_R:   return r;
            default: return '0;
        endcase
    endfunction

endpackage

// File: ap_reg_array.sv
module ap_reg_array
    import ap_pkg::*;
(
    input  logic        sys_clk_i,
    input  logic        arst_n_i,
    input  logic        row_we_i,
    input  sel_e        row_sel_i,
    input  row_idx_t    row_idx_i,
    input  word_t       row_data_i,
    input  logic        col_we_i,
    input  sel_e        col_sel_i,
    input  row_idx_t    col_idx_i,
    input  column_t     col_data_i,
    input  logic        img_we_i,
    input  sel_e        img_sel_i,
    input  array_img_t  img_data_i,
    input  logic        clear_i,
    output array_img_t  a_img_o,
    output array_img_t  b_img_o,
    output array_img_t  r_img_o
);

    array_img_t img_q [1:3];    // Indexed by selector value

    for (genvar k = 1; k <= 3; k++) begin : g_arr
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                img_q[k] <= '0;
            end else if (clear_i) begin
                img_q[k] <= '0;
            end else if (img_we_i && img_sel_i == sel_e'(k)) begin
                img_q[k] <= img_data_i;
            end else if (row_we_i && row_sel_i == sel_e'(k)) begin
                img_q[k][row_idx_i] <= row_data_i;
            end else if (col_we_i && col_sel_i == sel_e'(k)) begin
                // Column bit r goes to row r
                for (int r = 0; r < AP_ROWS; r++) begin
                    img_q[k][r][col_idx_i[2:0]] <= col_data_i[r];
                end
            end
        end
    end

    assign a_img_o = img_q[1];
    assign b_img_o = img_q[2];
    assign r_img_o = img_q[3];

    // Slice and word units must never write in the same cycle
    a_one_write: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        $onehot0({row_we_i, col_we_i, img_we_i, clear_i}))
        else $error("more than one array write kind active");

endmodule

// File: ap_slice_unit.sv
module ap_slice_unit
    import ap_pkg::*;
(
    input  logic        sys_clk_i,
    input  logic        arst_n_i,
    input  logic        exec_en_i,
    input  op_e         exec_op_i,
    input  sel_e        exec_sel_i,
    input  row_idx_t    exec_idx_i,
    input  imm_t        exec_imm_i,
    input  array_img_t  a_img_i,
    input  array_img_t  b_img_i,
    input  array_img_t  r_img_i,
    output logic        row_we_o,
    output sel_e        row_sel_o,
    output row_idx_t    row_idx_o,
    output word_t       row_data_o,
    output logic        col_we_o,
    output sel_e        col_sel_o,
    output row_idx_t    col_idx_o,
    output column_t     col_data_o,
    output logic        rd_valid_o,
    output column_t     rd_data_o
);

    array_img_t src_img;
    column_t    rd_next;
    logic       store_hit;
    logic       rd_valid_q;
    column_t    rd_data_q;

    // Loads
    assign row_we_o   = exec_en_i && (exec_op_i == LOADRBR);
    assign row_sel_o  = exec_sel_i;
    assign row_idx_o  = exec_idx_i;
    assign row_data_o = exec_imm_i[7:0];   // Row value sits in the low byte

    assign col_we_o   = exec_en_i && (exec_op_i == LOADCBC);
    assign col_sel_o  = exec_sel_i;
    assign col_idx_o  = exec_idx_i;
    assign col_data_o = exec_imm_i;

    // Stores
    assign store_hit = exec_en_i && ((exec_op_i == STORERBR) || (exec_op_i == STORECBC));

    always_comb begin
        src_img = pick_img(exec_sel_i, a_img_i, b_img_i, r_img_i);
        rd_next = '0;
        if (exec_op_i == STORERBR) begin
            rd_next = column_t'(src_img[exec_idx_i]);
        end else begin
            for (int r = 0; r < AP_ROWS; r++) begin
                rd_next[r] = src_img[r][exec_idx_i[2:0]];
            end
        end
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= store_hit;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (store_hit) rd_data_q <= rd_next;
    end

    assign rd_valid_o = rd_valid_q;
    assign rd_data_o  = rd_data_q;

endmodule

// File: ap_tb.sv
module ap_tb
    import ap_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ISSUE_DEPTH    = 4;
    localparam int RESULT_CREDITS = 2;

    logic        sys_clk;
    logic        arst_n;
    logic        instr_valid;
    instr_t      instr;
    logic        result_credit;
    logic        instr_credit;
    logic        result_valid;
    column_t     result;

    logic [31:0] lfsr_q = 32'hb716;
    string       step_name [$];
    instr_t      step_instr [$];
    word_t       ref_mem [4][AP_ROWS];  // Indexed by selector, entry 0 stays zero
    int          sent          = 0;
    int          store_count   = 0;
    int          credits_given = 0;
    bit          table_ready   = 1'b0;

    ap_top #(
        .ISSUE_DEPTH    (ISSUE_DEPTH),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) i_ap_top (
        .sys_clk_i       (sys_clk),
        .arst_n_i        (arst_n),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .result_credit_i (result_credit),
        .instr_credit_o  (instr_credit),
        .result_valid_o  (result_valid),
        .result_o        (result)
    );

    ap_checker #(
        .RESULT_CREDITS (RESULT_CREDITS)
    ) i_checker (
        .sys_clk_i       (sys_clk),
        .arst_n_i        (arst_n),
        .result_valid_i  (result_valid),
        .result_i        (result),
        .instr_credit_i  (instr_credit),
        .result_credit_i (result_credit)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic add_step(input string name, input op_e op, input sel_e sel,
                            input int idx, input imm_t imm);
        step_name.push_back(name);
        step_instr.push_back({op, 8'(idx), sel, imm});
    endtask

    task automatic clear_model();
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < AP_ROWS; r++) ref_mem[s][r] = '0;
        end
    endtask

    task automatic build_table();
        logic [15:0] u;
        logic [15:0] v;
        logic [15:0] w;
        word_t       corner [6] = '{8'h00, 8'h7f, 8'h80, 8'h81, 8'hff, 8'h01};
        for (int r = 0; r < AP_ROWS; r++) begin
            take_bits(8, v);
            add_step("row_rt", LOADRBR, SEL_A, r, v);
            take_bits(8, v);
            add_step("row_rt", LOADRBR, SEL_B, r, v);
        end
        for (int r = 0; r < AP_ROWS; r++) begin
            add_step("row_rt", STORERBR, SEL_A, r, '0);
            add_step("row_rt", STORERBR, SEL_B, r, '0);
        end
        for (int b = 0; b < 8; b++) begin
            take_bits(16, v);
            add_step("col_load", LOADCBC, SEL_B, b, v);
        end
        for (int r = 0; r < AP_ROWS; r++) add_step("col_to_row", STORERBR, SEL_B, r, '0);
        for (int b = 0; b < 8; b++) add_step("row_to_col", STORECBC, SEL_A, b, '0);
        add_step("add", ADD, SEL_R, 0, '0);
        for (int r = 0; r < AP_ROWS; r++) add_step("add", STORERBR, SEL_R, r, '0);
        add_step("sub", SUB, SEL_R, 0, '0);
        for (int r = 0; r < AP_ROWS; r++) add_step("sub", STORERBR, SEL_R, r, '0);
        for (int k = 0; k < 6; k++) add_step("corner", LOADRBR, SEL_A, k, corner[k]);
        add_step("abs", ABS, SEL_R, 0, '0);
        for (int r = 0; r < 8; r++) add_step("abs", STORERBR, SEL_R, r, '0);
        add_step("tsc", TSC, SEL_R, 0, '0);
        for (int r = 0; r < 8; r++) add_step("tsc", STORERBR, SEL_R, r, '0);
        add_step("copy", COPY, SEL_B, int'(SEL_A), '0);   // B <= A
        for (int r = 0; r < AP_ROWS; r++) add_step("copy", STORERBR, SEL_B, r, '0);
        add_step("copy", STORECBC, SEL_B, 3, '0);
        add_step("reset", RESET, SEL_NONE, 0, '0);
        for (int r = 0; r < AP_ROWS; r += 4) begin
            add_step("reset", STORERBR, SEL_A, r, '0);
            add_step("reset", STORERBR, SEL_B, r, '0);
            add_step("reset", STORERBR, SEL_R, r, '0);
        end
        add_step("reset", STORECBC, SEL_R, 7, '0);
        // Mixed loads and stores at full rate
        for (int k = 0; k < 32; k++) begin
            take_bits(2, v);
            take_bits(4, w);
            case (v[1:0])
                2'd0: begin
                    take_bits(8, u);
                    add_step("burst", LOADRBR, SEL_A, w, u);
                end
                2'd1:    add_step("burst", STORERBR, SEL_A, w, '0);
                2'd2:    add_step("burst", STORECBC, SEL_A, w, '0);
                default: add_step("burst", STORERBR, SEL_R, w, '0);
            endcase
        end
    endtask

    // Reference model, applied in issue order
    task automatic model_step(input instr_t ins, input string name);
        op_e     op;
        sel_e    sel;
        int      idx;
        imm_t    imm;
        int      s;
        word_t   tmp [AP_ROWS];
        column_t res;
        op  = op_e'(ins[29:26]);
        idx = ins[21:18];
        sel = sel_e'(ins[17:16]);
        imm = ins[15:0];
        res = '0;
        for (int r = 0; r < AP_ROWS; r++) begin
            case (op)
                LOADRBR:  if (sel != SEL_NONE && r == idx) ref_mem[sel][r] = imm[7:0];
                LOADCBC:  if (sel != SEL_NONE) ref_mem[sel][r][idx % 8] = imm[r];
                STORERBR: if (r == idx) res = {8'h00, ref_mem[sel][r]};
                STORECBC: res[r] = ref_mem[sel][r][idx % 8];
                COPY:     tmp[r] = ref_mem[idx % 4][r];
                ADD:      ref_mem[3][r] = ref_mem[1][r] + ref_mem[2][r];
                SUB:      ref_mem[3][r] = ref_mem[1][r] - ref_mem[2][r];
                TSC:      ref_mem[3][r] = word_t'(-int'(ref_mem[1][r]));
                ABS: begin
                    s = $signed(ref_mem[1][r]);
                    ref_mem[3][r] = (s < 0) ? -s : s;   // -128 wraps to 8'h80
                end
                default: ;
            endcase
        end
        if (op == COPY && sel != SEL_NONE) begin
            for (int r = 0; r < AP_ROWS; r++) ref_mem[sel][r] = tmp[r];
        end
        if (op == RESET) clear_model();
        if (op == STORERBR || op == STORECBC) begin
            store_count++;
            i_checker.expect_result(name, res);
        end
    endtask

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    initial begin
        int idx;
        int errors;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        clear_model();
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge sys_clk);
        #1 arst_n = 1'b1;
        idx = 0;
        while (idx < step_instr.size()) begin
            @(posedge sys_clk);
            #1;
            if (sent < ISSUE_DEPTH + i_checker.icredit_count) begin
                instr_valid = 1'b1;
                instr       = step_instr[idx];
                model_step(step_instr[idx], step_name[idx]);
                sent++;
                idx++;
            end else begin
                instr_valid = 1'b0;
            end
        end
        @(posedge sys_clk);
        #1 instr_valid = 1'b0;
        while (i_checker.result_count < store_count || i_checker.icredit_count < sent) begin
            @(posedge sys_clk);
        end
        repeat (10) @(posedge sys_clk);     // Catch stray results
        i_checker.verify_totals(sent);
        errors = i_checker.value_errors + i_checker.proto_errors;
        $display("Done: %0d instructions, %0d value errors, %0d protocol errors",
                 sent, i_checker.value_errors, i_checker.proto_errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Result credits come back after random stretches
    initial begin
        int          hold;
        logic [15:0] v;
        hold          = 0;
        result_credit = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge sys_clk);
            #1;
            result_credit = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if (i_checker.result_count > credits_given) begin
                result_credit = 1'b1;
                credits_given++;
                take_bits(4, v);
                hold = int'(v);
            end
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = step_instr.size() * 20 + 200;
        repeat (limit) @(posedge sys_clk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: ap_top.sv
module ap_top
    import ap_pkg::*;
#(
    parameter int ISSUE_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic     sys_clk_i,
    input  logic     arst_n_i,
    input  logic     instr_valid_i,
    input  instr_t   instr_i,
    input  logic     result_credit_i,
    output logic     instr_credit_o,
    output logic     result_valid_o,
    output column_t  result_o
);

    logic       exec_en;
    op_e        exec_op;
    sel_e       exec_sel;
    row_idx_t   exec_idx;
    imm_t       exec_imm;
    logic       rd_valid;
    column_t    rd_data;

    logic       row_we;
    sel_e       row_sel;
    row_idx_t   row_idx;
    word_t      row_data;
    logic       col_we;
    sel_e       col_sel;
    row_idx_t   col_idx;
    column_t    col_data;
    logic       img_we;
    sel_e       img_sel;
    array_img_t img_data;
    logic       clear;

    array_img_t a_img;
    array_img_t b_img;
    array_img_t r_img;

    ap_issue #(
        .ISSUE_DEPTH    (ISSUE_DEPTH),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) i_ap_issue (
        .sys_clk_i       (sys_clk_i),
        .arst_n_i        (arst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .result_credit_i (result_credit_i),
        .rd_valid_i      (rd_valid),
        .rd_data_i       (rd_data),
        .instr_credit_o  (instr_credit_o),
        .exec_en_o       (exec_en),
        .exec_op_o       (exec_op),
        .exec_sel_o      (exec_sel),
        .exec_idx_o      (exec_idx),
        .exec_imm_o      (exec_imm),
        .result_valid_o  (result_valid_o),
        .result_o        (result_o)
    );

    ap_slice_unit i_ap_slice_unit (
        .sys_clk_i  (sys_clk_i),
        .arst_n_i   (arst_n_i),
        .exec_en_i  (exec_en),
        .exec_op_i  (exec_op),
        .exec_sel_i (exec_sel),
        .exec_idx_i (exec_idx),
        .exec_imm_i (exec_imm),
        .a_img_i    (a_img),
        .b_img_i    (b_img),
        .r_img_i    (r_img),
        .row_we_o   (row_we),
        .row_sel_o  (row_sel),
        .row_idx_o  (row_idx),
        .row_data_o (row_data),
        .col_we_o   (col_we),
        .col_sel_o  (col_sel),
        .col_idx_o  (col_idx),
        .col_data_o (col_data),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data)
    );

    ap_word_unit i_ap_word_unit (
        .exec_en_i  (exec_en),
        .exec_op_i  (exec_op),
        .exec_sel_i (exec_sel),
        .exec_idx_i (exec_idx),
        .a_img_i    (a_img),
        .b_img_i    (b_img),
        .r_img_i    (r_img),
        .img_we_o   (img_we),
        .img_sel_o  (img_sel),
        .img_data_o (img_data),
        .clear_o    (clear)
    );

    ap_reg_array i_ap_reg_array (
        .sys_clk_i  (sys_clk_i),
        .arst_n_i   (arst_n_i),
        .row_we_i   (row_we),
        .row_sel_i  (row_sel),
        .row_idx_i  (row_idx),
        .row_data_i (row_data),
        .col_we_i   (col_we),
        .col_sel_i  (col_sel),
        .col_idx_i  (col_idx),
        .col_data_i (col_data),
        .img_we_i   (img_we),
        .img_sel_i  (img_sel),
        .img_data_i (img_data),
        .clear_i    (clear),
        .a_img_o    (a_img),
        .b_img_o    (b_img),
        .r_img_o    (r_img)
    );

endmodule

// File: ap_word_unit.sv
module ap_word_unit
    import ap_pkg::*;
(
    input  logic        exec_en_i,
    input  op_e         exec_op_i,
    input  sel_e        exec_sel_i,
    input  row_idx_t    exec_idx_i,
    input  array_img_t  a_img_i,
    input  array_img_t  b_img_i,
    input  array_img_t  r_img_i,
    output logic        img_we_o,
    output sel_e        img_sel_o,
    output array_img_t  img_data_o,
    output logic        clear_o
);

    always_comb begin
        img_we_o   = 1'b0;
        img_sel_o  = SEL_R;     // Arithmetic always lands in R
        img_data_o = '0;
        if (exec_en_i) begin
            case (exec_op_i)
                ADD, SUB, TSC, ABS: begin
                    img_we_o = 1'b1;
                    for (int r = 0; r < AP_ROWS; r++) begin
                        case (exec_op_i)
                            ADD:     img_data_o[r] = a_img_i[r] + b_img_i[r];
                            SUB:     img_data_o[r] = a_img_i[r] - b_img_i[r];
                            TSC:     img_data_o[r] = 8'd0 - a_img_i[r];
                            default: begin
                                // 8'h80 negates to itself
                                img_data_o[r] = a_img_i[r][7] ? 8'd0 - a_img_i[r]
                                                              : a_img_i[r];
                            end
                        endcase
                    end
                end
                COPY: begin
                    img_we_o   = 1'b1;
                    img_sel_o  = exec_sel_i;
                    img_data_o = pick_img(sel_e'(exec_idx_i[1:0]), a_img_i, b_img_i,
                                          r_img_i);
                end
                default: begin
                    img_we_o = 1'b0;
                end
            endcase
        end
    end

    assign clear_o = exec_en_i && (exec_op_i == RESET);

endmodule
